// ==== dcache.f ====
+incdir+src
src/dcache_pkg.sv
src/dcache_way_memory.sv
src/dcache_controller.sv
src/dcache.sv
verif/dcache_asserts.sv
verif/dcache_tb_mem.sv
verif/dcache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the data cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
        --top-module dcache_tb -f dcache.f -o Vdcache_tb; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vdcache_tb > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Checks failed" "$LOG"; then
    echo "Testbench reported a failure"
    exit 1
fi

echo "Simulation finished without reported failures"
exit 0

// ==== src/dcache.sv ====
// Two-way set-associative write-back data cache
// Byte merge, way read select and bus address forming around the storage and FSM

`include "dcache_macros.svh"

module dcache
    import dcache_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        MemWriteM,
    input  logic        MemtoRegM,
    input  logic [31:0] VirtA,
    input  logic [31:0] WD,
    input  logic [3:0]  ByteMaskM,
    input  logic [31:0] HRData,
    input  logic        BusReady,
    output logic [31:0] RD,
    output logic        Stall,
    output logic        HRequestM,
    output logic        HWriteM,
    output logic [31:0] HAddr,
    output logic [31:0] HWData
);

    dcacheAddr_t addr;
    dcacheAddr_t busAddr;

    // Way memory lookup
    logic                        way0Valid;
    logic                        way1Valid;
    logic                        way0Dirty;
    logic                        way1Dirty;
    logic [`DCACHE_TAG_BITS-1:0] way0Tag;
    logic [`DCACHE_TAG_BITS-1:0] way1Tag;
    logic [31:0]                 way0Word;
    logic [31:0]                 way1Word;
    logic                        lruBit;

    // Controller strobes
    logic                           waySel;
    logic                           way0En;
    logic                           way1En;
    logic                           dataWe;
    logic                           tagWe;
    logic                           validIn;
    logic                           dirtyIn;
    logic                           useVictimTag;
    logic [`DCACHE_OFFSET_BITS-1:0] busWordOffset;
    logic                           useBusData;
    logic                           lruWe;
    logic                           lruIn;

    logic [31:0]                 selWord;
    logic [31:0]                 mergedWord;
    logic [31:0]                 wordIn;
    logic [`DCACHE_TAG_BITS-1:0] victimTag;

    // No TLB, virtual address used as physical
    assign addr.raw = VirtA;

    // Word of the selected way feeds loads and writeback data
    assign selWord = waySel ? way1Word : way0Word;
    assign RD      = selWord;
    assign HWData  = selWord;

    // Store bytes over the cached word
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            mergedWord[b*8 +: 8] = ByteMaskM[b] ? WD[b*8 +: 8] : selWord[b*8 +: 8];
        end
    end

    assign wordIn = useBusData ? HRData : mergedWord;

    // Bus address, victim tag only during writeback
    assign victimTag                  = waySel ? way1Tag : way0Tag;
    assign busAddr.fields.tag         = useVictimTag ? victimTag : addr.fields.tag;
    assign busAddr.fields.setIndex    = addr.fields.setIndex;
    assign busAddr.fields.wordOffset  = busWordOffset;
    assign busAddr.fields.byteOffset  = 2'b00;
    assign HAddr                      = busAddr.raw;

    dcache_way_memory wayMem (
        .clk        (clk),
        .rst        (rst),
        .setIndex   (addr.fields.setIndex),
        .wordOffset (busWordOffset),
        .way0En     (way0En),
        .way1En     (way1En),
        .dataWe     (dataWe),
        .tagWe      (tagWe),
        .validIn    (validIn),
        .dirtyIn    (dirtyIn),
        .tagIn      (addr.fields.tag),
        .wordIn     (wordIn),
        .lruWe      (lruWe),
        .lruIn      (lruIn),
        .way0Valid  (way0Valid),
        .way1Valid  (way1Valid),
        .way0Dirty  (way0Dirty),
        .way1Dirty  (way1Dirty),
        .way0Tag    (way0Tag),
        .way1Tag    (way1Tag),
        .way0Word   (way0Word),
        .way1Word   (way1Word),
        .lruBit     (lruBit)
    );

    dcache_controller ctrl (
        .clk           (clk),
        .rst           (rst),
        .MemWriteM     (MemWriteM),
        .MemtoRegM     (MemtoRegM),
        .BusReady      (BusReady),
        .addr          (addr),
        .way0Valid     (way0Valid),
        .way1Valid     (way1Valid),
        .way0Dirty     (way0Dirty),
        .way1Dirty     (way1Dirty),
        .way0Tag       (way0Tag),
        .way1Tag       (way1Tag),
        .lruBit        (lruBit),
        .Stall         (Stall),
        .HRequestM     (HRequestM),
        .HWriteM       (HWriteM),
        .waySel        (waySel),
        .way0En        (way0En),
        .way1En        (way1En),
        .dataWe        (dataWe),
        .tagWe         (tagWe),
        .validIn       (validIn),
        .dirtyIn       (dirtyIn),
        .useVictimTag  (useVictimTag),
        .busWordOffset (busWordOffset),
        .useBusData    (useBusData),
        .lruWe         (lruWe),
        .lruIn         (lruIn)
    );

endmodule

// ==== src/dcache_controller.sv ====
// Data cache controller
// Hit detection, victim choice and the writeback/fill burst FSM

`include "dcache_macros.svh"

module dcache_controller
    import dcache_pkg::*;
(
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           MemWriteM,
    input  logic                           MemtoRegM,
    input  logic                           BusReady,
    input  dcacheAddr_t                    addr,
    input  logic                           way0Valid,
    input  logic                           way1Valid,
    input  logic                           way0Dirty,
    input  logic                           way1Dirty,
    input  logic [`DCACHE_TAG_BITS-1:0]    way0Tag,
    input  logic [`DCACHE_TAG_BITS-1:0]    way1Tag,
    input  logic                           lruBit,
    output logic                           Stall,
    output logic                           HRequestM,
    output logic                           HWriteM,
    output logic                           waySel,
    output logic                           way0En,
    output logic                           way1En,
    output logic                           dataWe,
    output logic                           tagWe,
    output logic                           validIn,
    output logic                           dirtyIn,
    output logic                           useVictimTag,
    output logic [`DCACHE_OFFSET_BITS-1:0] busWordOffset,
    output logic                           useBusData,
    output logic                           lruWe,
    output logic                           lruIn
);

    cacheState_t state;
    cacheState_t stateNext;

    logic [`DCACHE_OFFSET_BITS-1:0] wordCount;
    logic                           lastWord;

    logic request;
    logic hit0;
    logic hit1;
    logic hit;
    logic victimWay;
    logic victimDirty;
    logic victimQ;

    assign request = MemWriteM | MemtoRegM;

    // Tag compare on both ways
    assign hit0 = way0Valid && (way0Tag == addr.fields.tag);
    assign hit1 = way1Valid && (way1Tag == addr.fields.tag);
    assign hit  = hit0 | hit1;

    // Invalid way first, otherwise the LRU way
    always_comb begin
        if (!way0Valid) begin
            victimWay = 1'b0;
        end else if (!way1Valid) begin
            victimWay = 1'b1;
        end else begin
            victimWay = lruBit;
        end
    end

    assign victimDirty = victimWay ? way1Dirty : way0Dirty;

    // Victim held for the whole miss sequence
    always_ff @(posedge clk) begin
        if (state == Idle) begin
            victimQ <= victimWay;
        end
    end

    // Block size is a power of two, so the last word is all ones
    assign lastWord = &wordCount;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= Idle;
            wordCount <= '0;
        end else begin
            state <= stateNext;
            if (state == Idle) begin
                wordCount <= '0;
            end else if (BusReady) begin
                // Wraps to zero between writeback and fill
                wordCount <= wordCount + 1'b1;
            end
        end
    end

    always_comb begin
        stateNext = state;
        case (state)
            Idle: begin
                if (request && !hit) begin
                    stateNext = victimDirty ? WriteBack : Fill;
                end
            end
            WriteBack: begin
                if (BusReady && lastWord) begin
                    stateNext = Fill;
                end
            end
            Fill: begin
                if (BusReady && lastWord) begin
                    stateNext = Idle;
                end
            end
            default: stateNext = Idle;
        endcase
    end

    // Array write strobes
    always_comb begin
        dataWe  = 1'b0;
        tagWe   = 1'b0;
        validIn = 1'b0;
        dirtyIn = 1'b0;
        lruWe   = 1'b0;
        case (state)
            Idle: begin
                if (request && hit) begin
                    lruWe = 1'b1;
                    if (MemWriteM) begin
                        dataWe  = 1'b1;
                        tagWe   = 1'b1;
                        validIn = 1'b1;
                        dirtyIn = 1'b1;
                    end
                end
            end
            Fill: begin
                if (BusReady) begin
                    dataWe  = 1'b1;
                    // Tag goes in with the last word, block clean
                    tagWe   = lastWord;
                    validIn = lastWord;
                end
            end
            default: ;
        endcase
    end

    // Hit way while idle, victim during bursts
    assign waySel = (state == Idle) ? (hit ? hit1 : victimWay) : victimQ;
    assign way0En = ~waySel;
    assign way1En = waySel;

    // LRU names the way that was not just used
    assign lruIn = ~waySel;

    assign busWordOffset = (state == Idle) ? addr.fields.wordOffset : wordCount;
    assign useVictimTag  = (state == WriteBack);
    assign useBusData    = (state == Fill);

    // Bus levels come straight from the state
    assign HRequestM = (state != Idle);
    assign HWriteM   = (state == WriteBack);

    assign Stall = request && !((state == Idle) && hit);

endmodule

// ==== src/dcache_macros.svh ====
// Data cache geometry macros
// Block size, set count and the split of the 30-bit word address

`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// Words per block, also the length of every bus burst
`define DCACHE_BLOCK_WORDS 4

// Number of sets in each way
`define DCACHE_SETS 2

// Word offset within a block
`define DCACHE_OFFSET_BITS ($clog2(`DCACHE_BLOCK_WORDS))

// Set index
`define DCACHE_INDEX_BITS ($clog2(`DCACHE_SETS))

// Tag takes whatever is left of the word address
`define DCACHE_TAG_BITS (30 - `DCACHE_OFFSET_BITS - `DCACHE_INDEX_BITS)

`endif

// ==== src/dcache_pkg.sv ====
// Data cache shared types
// Address views and the miss FSM state encoding

`include "dcache_macros.svh"

package dcache_pkg;

    // Address split into cache fields, MSB first
    typedef struct packed {
        logic [`DCACHE_TAG_BITS-1:0]    tag;
        logic [`DCACHE_INDEX_BITS-1:0]  setIndex;
        logic [`DCACHE_OFFSET_BITS-1:0] wordOffset;
        logic [1:0]                     byteOffset;
    } dcacheAddrFields_t;

    // Same 32 bits seen as a raw word or as cache fields
    typedef union packed {
        logic [31:0]       raw;
        dcacheAddrFields_t fields;
    } dcacheAddr_t;

    // Miss handling states
    typedef enum logic [1:0] {
        Idle,
        WriteBack,
        Fill
    } cacheState_t;

endpackage

// ==== src/dcache_way_memory.sv ====
// Two-way storage for the data cache
// Block data, tags, valid and dirty bits per way, plus one LRU bit per set

`include "dcache_macros.svh"

module dcache_way_memory (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [`DCACHE_INDEX_BITS-1:0]  setIndex,
    input  logic [`DCACHE_OFFSET_BITS-1:0] wordOffset,
    input  logic                           way0En,
    input  logic                           way1En,
    input  logic                           dataWe,
    input  logic                           tagWe,
    input  logic                           validIn,
    input  logic                           dirtyIn,
    input  logic [`DCACHE_TAG_BITS-1:0]    tagIn,
    input  logic [31:0]                    wordIn,
    input  logic                           lruWe,
    input  logic                           lruIn,
    output logic                           way0Valid,
    output logic                           way1Valid,
    output logic                           way0Dirty,
    output logic                           way1Dirty,
    output logic [`DCACHE_TAG_BITS-1:0]    way0Tag,
    output logic [`DCACHE_TAG_BITS-1:0]    way1Tag,
    output logic [31:0]                    way0Word,
    output logic [31:0]                    way1Word,
    output logic                           lruBit
);

    // Block data, one word per entry
    logic [31:0] dataMem [2][`DCACHE_SETS][`DCACHE_BLOCK_WORDS];

    // Per-set tags for each way
    logic [`DCACHE_TAG_BITS-1:0] tagMem [2][`DCACHE_SETS];

    // Status bits, one vector per way
    logic [`DCACHE_SETS-1:0] validMem [2];
    logic [`DCACHE_SETS-1:0] dirtyMem [2];

    // Way to evict next in each set
    logic [`DCACHE_SETS-1:0] lruMem;

    logic [1:0] wayEn;

    assign wayEn = {way1En, way0En};

    // Data and tag storage
    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (wayEn[w] && dataWe) begin
                dataMem[w][setIndex][wordOffset] <= wordIn;
            end
            if (wayEn[w] && tagWe) begin
                tagMem[w][setIndex] <= tagIn;
            end
        end
    end

    // Valid and dirty are written together with the tag
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < 2; w++) begin
                validMem[w] <= '0;
                dirtyMem[w] <= '0;
            end
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (wayEn[w] && tagWe) begin
                    validMem[w][setIndex] <= validIn;
                    dirtyMem[w][setIndex] <= dirtyIn;
                end
            end
        end
    end

    // Replacement state
    always_ff @(posedge clk) begin
        if (rst) begin
            lruMem <= '0;
        end else if (lruWe) begin
            lruMem[setIndex] <= lruIn;
        end
    end

    // Combinational lookup of the addressed set
    assign way0Valid = validMem[0][setIndex];
    assign way1Valid = validMem[1][setIndex];
    assign way0Dirty = dirtyMem[0][setIndex];
    assign way1Dirty = dirtyMem[1][setIndex];
    assign way0Tag   = tagMem[0][setIndex];
    assign way1Tag   = tagMem[1][setIndex];

    // Addressed word of each way
    assign way0Word = dataMem[0][setIndex][wordOffset];
    assign way1Word = dataMem[1][setIndex][wordOffset];

    assign lruBit = lruMem[setIndex];

endmodule

// ==== verif/dcache_asserts.sv ====
// Protocol checks for the data cache controller
// Bus request levels, pending transfer stability and stall behavior

`include "dcache_macros.svh"

module dcache_asserts
    import dcache_pkg::*;
(
    input logic                           clk,
    input logic                           rst,
    input logic                           BusReady,
    input dcacheAddr_t                    addr,
    input logic [`DCACHE_OFFSET_BITS-1:0] busWordOffset,
    input logic                           useVictimTag,
    input logic                           HRequestM,
    input logic                           HWriteM,
    input logic                           Stall,
    input cacheState_t                    state
);
    timeunit 1ns;
    timeprecision 1ps;

    // Bus is quiet right after reset
    assert property (@(posedge clk) rst |=> !HRequestM)
        else $error("HRequestM high in the cycle after reset");

    // Address and direction hold until ready
    assert property (@(posedge clk) disable iff (rst)
        (HRequestM && !BusReady) |=> ($stable(addr) && $stable(busWordOffset)
            && $stable(useVictimTag) && $stable(HWriteM)))
        else $error("Bus address or direction changed while a transfer was pending");

    // A finished fill leaves the block resident so the access hits at once
    assert property (@(posedge clk) disable iff (rst)
        (($past(state) == Fill) && (state == Idle)) |-> !Stall)
        else $error("Access still stalled after its block was filled");

endmodule

bind dcache_controller dcache_asserts protocolChecks (
    .clk           (clk),
    .rst           (rst),
    .BusReady      (BusReady),
    .addr          (addr),
    .busWordOffset (busWordOffset),
    .useVictimTag  (useVictimTag),
    .HRequestM     (HRequestM),
    .HWriteM       (HWriteM),
    .Stall         (Stall),
    .state         (state)
);

// ==== verif/dcache_tb.sv ====
// Testbench for the two-way write-back data cache
// LFSR driven loads and stores checked against a shadow memory

module dcache_tb
    import dcache_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MemWords  = 64;
    localparam int WaitLimit = 200;

    logic        clk;
    logic        rst;
    logic        MemWriteM;
    logic        MemtoRegM;
    logic [31:0] VirtA;
    logic [31:0] WD;
    logic [3:0]  ByteMaskM;
    logic [31:0] HRData;
    logic        BusReady;
    logic [31:0] RD;
    logic        Stall;
    logic        HRequestM;
    logic        HWriteM;
    logic [31:0] HAddr;
    logic [31:0] HWData;

    logic [31:0] shadow [MemWords];
    logic [31:0] lfsr;
    logic [1:0]  beatCount;

    // Tags held by each set and way, and the way to evict next
    logic [2:0] refTag [2][2];
    logic       refValid [2][2];
    logic       refLru [2];
    logic [2:0] expectedVictim;

    dcache DUT (
        .clk       (clk),
        .rst       (rst),
        .MemWriteM (MemWriteM),
        .MemtoRegM (MemtoRegM),
        .VirtA     (VirtA),
        .WD        (WD),
        .ByteMaskM (ByteMaskM),
        .HRData    (HRData),
        .BusReady  (BusReady),
        .RD        (RD),
        .Stall     (Stall),
        .HRequestM (HRequestM),
        .HWriteM   (HWriteM),
        .HAddr     (HAddr),
        .HWData    (HWData)
    );

    dcache_tb_mem memory (
        .clk       (clk),
        .rst       (rst),
        .HRequestM (HRequestM),
        .HWriteM   (HWriteM),
        .HAddr     (HAddr),
        .HWData    (HWData),
        .HRData    (HRData),
        .BusReady  (BusReady)
    );

    always #50 clk = ~clk;

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Checks failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic checkData(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
        if (actual !== expected) begin
            abortRun($sformatf("Error at %0t ns: %s is %h, expected %h",
                               $time, name, actual, expected));
        end
    endtask

    task automatic checkBusAddr(input string name, input dcacheAddr_t actual,
                                input dcacheAddr_t expected);
        if (actual.raw !== expected.raw) begin
            abortRun($sformatf("Error at %0t ns: %s is %h, expected %h",
                               $time, name, actual.raw, expected.raw));
        end
    endtask

    task automatic checkFlag(input string name, input bit actual, input bit expected);
        if (actual !== expected) begin
            abortRun($sformatf("Error at %0t ns: %s is %b, expected %b",
                               $time, name, actual, expected));
        end
    endtask

    // Fibonacci LFSR with taps 32 22 2 1
    // One step per bit taken
    function automatic logic [31:0] takeBits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr  = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            value = {value[30:0], lfsr[0]};
        end
        return value;
    endfunction

    // Byte address from tag, set and word offset
    function automatic logic [31:0] wordAddr(input logic [2:0] tag, input logic setBit,
                                             input logic [1:0] offset);
        return {24'h0, tag, setBit, offset, 2'b00};
    endfunction

    // Expected load word straight from the shadow memory
    function automatic logic [31:0] expectedLoad(input logic [31:0] a);
        return shadow[a[7:2]];
    endfunction

    // Tag model of the two ways
    task automatic trackTags(input logic [31:0] a, output logic isHit);
        logic [2:0] t;
        logic       s;
        logic       w;
        t     = a[7:5];
        s     = a[4];
        isHit = 1'b1;
        if (refValid[s][0] && refTag[s][0] == t) begin
            w = 1'b0;
        end else if (refValid[s][1] && refTag[s][1] == t) begin
            w = 1'b1;
        end else begin
            isHit = 1'b0;
            // Invalid way first, otherwise the LRU way
            if (!refValid[s][0]) begin
                w = 1'b0;
            end else if (!refValid[s][1]) begin
                w = 1'b1;
            end else begin
                w = refLru[s];
            end
            expectedVictim = refTag[s][w];
            refTag[s][w]   = t;
            refValid[s][w] = 1'b1;
        end
        refLru[s] = ~w;
    endtask

    // One access held until Stall is low at a clock edge
    task automatic access(input logic isStore, input logic [31:0] a, input logic [31:0] data,
                          input logic [3:0] mask, output logic sawRequest);
        int   n;
        logic expectHit;
        trackTags(a, expectHit);
        sawRequest = 1'b0;
        VirtA      = a;
        WD         = data;
        ByteMaskM  = mask;
        MemWriteM  = isStore;
        MemtoRegM  = !isStore;
        for (n = 0; n < WaitLimit; n++) begin
            @(negedge clk);
            if (HRequestM) begin
                sawRequest = 1'b1;
            end
            if (!Stall) begin
                break;
            end
        end
        if (n == WaitLimit) begin
            abortRun("Timeout: Stall never went low for an access");
        end
        checkFlag("Stall in the first access cycle", n != 0, !expectHit);
        checkFlag("HRequestM during the access", sawRequest, !expectHit);
        @(posedge clk);
        #1;
        if (isStore) begin
            for (int b = 0; b < 4; b++) begin
                if (mask[b]) begin
                    shadow[a[7:2]][b*8 +: 8] = data[b*8 +: 8];
                end
            end
        end
        MemWriteM = 1'b0;
        MemtoRegM = 1'b0;
    endtask

    // Load results against the reference model
    always @(negedge clk) begin
        if (!rst && MemtoRegM && !Stall) begin
            checkData("RD", RD, expectedLoad(VirtA));
        end
    end

    // Bus transfers in ascending offset order within the expected block
    always @(negedge clk) begin
        dcacheAddr_t seen;
        dcacheAddr_t want;
        if (!rst && HRequestM && BusReady) begin
            seen.raw               = HAddr;
            want.raw               = VirtA;
            want.fields.wordOffset = beatCount;
            want.fields.byteOffset = 2'b00;
            if (HWriteM) begin
                // Writeback carries the tag of the evicted block
                want.fields.tag      = '0;
                want.fields.tag[2:0] = expectedVictim;
            end
            checkBusAddr("HAddr", seen, want);
            beatCount = beatCount + 2'd1;
        end
    end

    initial begin
        logic        saw;
        logic        isStore;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] r;
        logic [3:0]  m;
        clk       = 1'b0;
        rst       = 1'b1;
        MemWriteM = 1'b0;
        MemtoRegM = 1'b0;
        VirtA     = '0;
        WD        = '0;
        ByteMaskM = '0;
        lfsr      = 32'hc88a_94b3;
        beatCount = '0;
        expectedVictim = '0;
        for (int s = 0; s < 2; s++) begin
            refLru[s] = 1'b0;
            for (int w = 0; w < 2; w++) begin
                refTag[s][w]   = '0;
                refValid[s][w] = 1'b0;
            end
        end
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int i = 0; i < MemWords; i++) begin
            shadow[i] = memory.mem[i];
        end

        // Cold miss followed by hits in the same block
        access(1'b0, wordAddr(3'd0, 1'b0, 2'd0), '0, '0, saw);
        checkFlag("bus request on cold miss", saw, 1'b1);
        for (int i = 1; i < 4; i++) begin
            access(1'b0, wordAddr(3'd0, 1'b0, i[1:0]), '0, '0, saw);
            checkFlag("bus request on block hit", saw, 1'b0);
        end

        // Byte-masked stores read back merged
        for (int i = 0; i < 8; i++) begin
            a = wordAddr(3'd0, 1'b0, i[1:0]);
            d = takeBits(32);
            r = takeBits(4);
            m = r[3:0];
            access(1'b1, a, d, m, saw);
            access(1'b0, a, '0, '0, saw);
        end

        // LRU in set 1 with A B A C keeps A resident
        access(1'b0, wordAddr(3'd0, 1'b1, 2'd0), '0, '0, saw);
        access(1'b0, wordAddr(3'd1, 1'b1, 2'd0), '0, '0, saw);
        access(1'b0, wordAddr(3'd0, 1'b1, 2'd1), '0, '0, saw);
        access(1'b0, wordAddr(3'd2, 1'b1, 2'd0), '0, '0, saw);
        access(1'b0, wordAddr(3'd0, 1'b1, 2'd2), '0, '0, saw);
        checkFlag("bus request for recently used block", saw, 1'b0);

        // Three tags in set 0 force dirty evictions
        for (int round = 0; round < 4; round++) begin
            for (int t = 0; t < 3; t++) begin
                r = takeBits(2);
                d = takeBits(32);
                access(1'b1, wordAddr(t[2:0], 1'b0, r[1:0]), d, 4'hf, saw);
            end
        end

        // Random mix over tags 0 to 3
        for (int i = 0; i < 400; i++) begin
            r       = takeBits(5);
            a       = wordAddr({1'b0, r[4:3]}, r[2], r[1:0]);
            r       = takeBits(1);
            isStore = r[0];
            d       = takeBits(32);
            r       = takeBits(4);
            m       = r[3:0];
            access(isStore, a, d, m, saw);
        end

        // Tags 4 and 5 are never stored, so both ways end up clean
        for (int s = 0; s < 2; s++) begin
            access(1'b0, wordAddr(3'd4, s[0], 2'd0), '0, '0, saw);
            access(1'b0, wordAddr(3'd5, s[0], 2'd0), '0, '0, saw);
        end
        for (int i = 0; i < MemWords; i++) begin
            checkData($sformatf("memory word %0d", i), memory.mem[i], shadow[i]);
        end

        $display("All checks passed");
        $finish;
    end

endmodule

// ==== verif/dcache_tb_mem.sv ====
// Backing memory for the cache testbench
// Answers single word transfers after a varying number of cycles

module dcache_tb_mem (
    input  logic        clk,
    input  logic        rst,
    input  logic        HRequestM,
    input  logic        HWriteM,
    input  logic [31:0] HAddr,
    input  logic [31:0] HWData,
    output logic [31:0] HRData,
    output logic        BusReady
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [31:0] mem [64];
    logic [1:0]  waitCount;
    logic [2:0]  delayStep;

    // Fill pattern spread over every address bit
    initial begin
        for (int i = 0; i < 64; i++) begin
            mem[i] = 32'hc0de_0000 ^ (i * 32'h0101_0404);
        end
        HRData    = '0;
        BusReady  = 1'b0;
        waitCount = '0;
        delayStep = '0;
    end

    // Sample at the edge, drive outputs shortly after
    always @(posedge clk) begin
        logic        ready;
        logic [31:0] data;
        ready = 1'b0;
        data  = HRData;
        if (rst) begin
            waitCount = '0;
        end else if (HRequestM && !BusReady) begin
            if (waitCount == delayStep[2:1]) begin
                ready     = 1'b1;
                waitCount = '0;
                // Next transfer gets a different delay
                delayStep = delayStep + 3'd3;
                if (HWriteM) begin
                    mem[HAddr[7:2]] = HWData;
                end else begin
                    data = mem[HAddr[7:2]];
                end
            end else begin
                waitCount = waitCount + 2'd1;
            end
        end
        #1;
        BusReady = ready;
        HRData   = data;
    end

endmodule
